// ==== src/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  // instruction classes as kept in the reorder buffer
  typedef enum logic [3:0] {
    OP,
    OPIMM,
    LUI,
    JAL,
    JALR,
    LOAD,
    STORE,
    BRANCH,
    MUL,
    DIV
  } itype_e;

  // rv32i major opcodes, bits [6:0] of the instruction word
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // m extension lives under OP with this funct7
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // architectural register file shape
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

endpackage

`default_nettype wire

// ==== src/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

  // data path width
  localparam int XLEN = 32;

  // eight entries, three index bits
  localparam int ROB_SIZE = 8;
  localparam int ROB_IX_W = 3;

  // slot index into the entry arrays
  typedef logic [ROB_IX_W-1:0] rob_ix_t;

  // head and tail pointers carry one extra wrap bit
  // so tail - head gives the occupancy directly
  // and 8 entries is distinct from empty
  typedef logic [ROB_IX_W:0] rob_ptr_t;

endpackage

`default_nettype wire

// ==== src/rob_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// issue unit to reorder buffer allocation path
interface issue_if;
  import rv_isa_pkg::*;
  import rob_pkg::*;

  logic              valid;
  itype_e            itype;
  logic [XLEN-1:0]   value;
  logic [XLEN-1:0]   dest;
  // current tail slot and full level from the buffer
  rob_ix_t           rob_ix;
  logic              rob_full;

  modport producer (output valid, itype, value, dest, input rob_ix, rob_full);
  modport buffer (input valid, itype, value, dest, output rob_ix, rob_full);
endinterface

// reorder buffer head to retire path
interface commit_if;
  import rv_isa_pkg::*;
  import rob_pkg::*;

  // one cycle per entry for non-store classes
  logic              commit;
  // held until acknowledged
  logic              store_valid;
  logic              store_ack;
  rob_ix_t           ix;
  itype_e            itype;
  logic [XLEN-1:0]   value;
  logic [XLEN-1:0]   dest;

  modport buffer (output commit, store_valid, ix, itype, value, dest, input store_ack);
  modport retire (input commit, store_valid, ix, itype, value, dest, output store_ack);
endinterface

`default_nettype wire

// ==== src/issue_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_unit (
  input  wire logic                            clk_in,
  input  wire logic                            rst_in,
  input  wire logic                            instr_valid_in,
  input  wire logic [6:0]                      opcode_in,
  input  wire logic [6:0]                      funct7_in,
  input  wire logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_in,
  input  wire logic [rob_pkg::XLEN-1:0]        imm_in,
  input  wire logic                            pred_taken_in,
  input  wire logic [rob_pkg::XLEN-1:0]        target_in,
  output logic                                 busy_out,
  output rob_pkg::rob_ix_t                     issue_ix_out,
  issue_if.producer                            issue
);
  import rv_isa_pkg::*;
  import rob_pkg::*;

  itype_e          itype_d;
  logic [XLEN-1:0] value_d;
  logic [XLEN-1:0] dest_d;

  // one-entry holding register
  logic            held_q;
  itype_e          itype_q;
  logic [XLEN-1:0] value_q;
  logic [XLEN-1:0] dest_q;

  // opcode to class, unknown opcodes fall back to OP
  // r-type has no immediate, so funct3 rides in imm_in[2:0]
  always_comb begin
    unique case (opcode_in)
      OPC_OP:     begin
        if (funct7_in == FUNCT7_MULDIV) begin
          // funct3 bit 2 set is div/rem
          itype_d = imm_in[2] ? DIV : MUL;
        end else begin
          itype_d = OP;
        end
      end
      OPC_OPIMM:  itype_d = OPIMM;
      OPC_LUI:    itype_d = LUI;
      OPC_JAL:    itype_d = JAL;
      OPC_JALR:   itype_d = JALR;
      OPC_LOAD:   itype_d = LOAD;
      OPC_STORE:  itype_d = STORE;
      OPC_BRANCH: itype_d = BRANCH;
      default:    itype_d = OP;
    endcase
  end

  // entry payload per class
  always_comb begin
    value_d = imm_in;
    dest_d  = XLEN'(rd_in);
    case (itype_d)
      // predicted outcome and target
      BRANCH: begin
        value_d = XLEN'(pred_taken_in);
        dest_d  = target_in;
      end
      // offset now, base added on the CDB write
      STORE:  dest_d = imm_in;
      default: ;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      held_q <= 1'b0;
    end else if (held_q) begin
      // released once the buffer has room
      if (!issue.rob_full) begin
        held_q <= 1'b0;
      end
    end else if (instr_valid_in) begin
      held_q <= 1'b1;
    end
  end

  // payload and issued index carry no reset
  always_ff @(posedge clk_in) begin
    if (!held_q && instr_valid_in) begin
      itype_q <= itype_d;
      value_q <= value_d;
      dest_q  <= dest_d;
    end
    if (held_q && !issue.rob_full) begin
      issue_ix_out <= issue.rob_ix;
    end
  end

  assign busy_out    = held_q;
  assign issue.valid = held_q;
  assign issue.itype = itype_q;
  assign issue.value = value_q;
  assign issue.dest  = dest_q;

endmodule

`default_nettype wire

// ==== src/rob.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob (
  input  wire logic                     clk_in,
  input  wire logic                     rst_in,
  issue_if.buffer                       issue,
  commit_if.buffer                      commit,
  // common data bus write-back
  input  wire logic                     cdb_valid_in,
  input  wire rob_pkg::rob_ix_t         cdb_ix_in,
  input  wire logic [rob_pkg::XLEN-1:0] cdb_value_in,
  input  wire logic [rob_pkg::XLEN-1:0] cdb_dest_in,
  // operand lookups from decode
  input  wire rob_pkg::rob_ix_t         lookup1_ix_in,
  input  wire rob_pkg::rob_ix_t         lookup2_ix_in,
  output logic [rob_pkg::XLEN-1:0]      lookup1_value_out,
  output logic                          lookup1_ready_out,
  output logic [rob_pkg::XLEN-1:0]      lookup2_value_out,
  output logic                          lookup2_ready_out,
  // fetch redirect on mispredict
  output logic                          redirect_out,
  output logic [rob_pkg::XLEN-1:0]      redirect_pc_out
);
  import rv_isa_pkg::*;
  import rob_pkg::*;

  // entry storage
  itype_e              itype_q [ROB_SIZE];
  logic [XLEN-1:0]     value_q [ROB_SIZE];
  logic [XLEN-1:0]     dest_q  [ROB_SIZE];
  logic [ROB_SIZE-1:0] ready_q;

  rob_ptr_t head_q;
  rob_ptr_t tail_q;
  rob_ptr_t count;
  rob_ix_t  head_ix;
  rob_ix_t  tail_ix;
  rob_ix_t  cdb_off;
  logic     full;
  logic     alloc;
  logic     cdb_live;
  logic     mispredict;
  logic     head_ok;
  logic     advance;

  assign head_ix = head_q[ROB_IX_W-1:0];
  assign tail_ix = tail_q[ROB_IX_W-1:0];
  assign count   = tail_q - head_q;
  assign full    = (count == rob_ptr_t'(ROB_SIZE));
  assign alloc   = issue.valid && !full;

  // distance of the cdb slot from head, only live entries take a write
  assign cdb_off  = cdb_ix_in - head_ix;
  assign cdb_live = cdb_valid_in && ({1'b0, cdb_off} < count) && !ready_q[cdb_ix_in];

  // outcome bit against the prediction stored at issue
  assign mispredict = cdb_live && (itype_q[cdb_ix_in] == BRANCH)
                      && (value_q[cdb_ix_in][0] != cdb_value_in[0]);

  // head presentation, split by class
  assign head_ok            = (count != '0) && ready_q[head_ix];
  assign commit.commit      = head_ok && (itype_q[head_ix] != STORE);
  assign commit.store_valid = head_ok && (itype_q[head_ix] == STORE);
  assign commit.ix          = head_ix;
  assign commit.itype       = itype_q[head_ix];
  assign commit.value       = value_q[head_ix];
  assign commit.dest        = dest_q[head_ix];

  // store waits for the ack, others go in one cycle
  assign advance = commit.commit || (commit.store_valid && commit.store_ack);

  assign issue.rob_ix   = tail_ix;
  assign issue.rob_full = full;

  // operand bypass for decode
  assign lookup1_value_out = value_q[lookup1_ix_in];
  assign lookup1_ready_out = ready_q[lookup1_ix_in];
  assign lookup2_value_out = value_q[lookup2_ix_in];
  assign lookup2_ready_out = ready_q[lookup2_ix_in];

  // pointers, ready bits, redirect strobe
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head_q       <= '0;
      tail_q       <= '0;
      ready_q      <= '0;
      redirect_out <= 1'b0;
    end else begin
      redirect_out <= mispredict;
      if (advance) begin
        head_q <= head_q + 1'b1;
      end
      if (alloc) begin
        ready_q[tail_ix] <= 1'b0;
      end
      if (cdb_live) begin
        ready_q[cdb_ix_in] <= 1'b1;
      end
      // squash: tail lands just past the branch, wrap bit kept from head
      if (mispredict) begin
        tail_q <= head_q + {1'b0, cdb_off} + 1'b1;
      end else if (alloc) begin
        tail_q <= tail_q + 1'b1;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk_in) begin
    if (alloc) begin
      itype_q[tail_ix] <= issue.itype;
      value_q[tail_ix] <= issue.value;
      dest_q[tail_ix]  <= issue.dest;
    end
    if (cdb_live) begin
      value_q[cdb_ix_in] <= cdb_value_in;
      // base plus the offset recorded at issue
      if (itype_q[cdb_ix_in] == STORE) begin
        dest_q[cdb_ix_in] <= dest_q[cdb_ix_in] + cdb_dest_in;
      end
    end
    if (mispredict) begin
      redirect_pc_out <= dest_q[cdb_ix_in];
    end
  end

endmodule

`default_nettype wire

// ==== src/commit_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_unit (
  input  wire logic                              clk_in,
  input  wire logic                              rst_in,
  commit_if.retire                               commit,
  // store port to memory
  output logic                                   store_valid_out,
  output logic [rob_pkg::XLEN-1:0]               store_addr_out,
  output logic [rob_pkg::XLEN-1:0]               store_data_out,
  input  wire logic                              store_ack_in,
  // register file read port
  input  wire logic [rv_isa_pkg::REG_ADDR_W-1:0] reg_addr_in,
  output logic [rob_pkg::XLEN-1:0]               reg_data_out,
  output logic                                   retire_out
);
  import rv_isa_pkg::*;
  import rob_pkg::*;

  // architectural registers, x0 handled on read and write
  logic [XLEN-1:0]       regs [NUM_REGS];
  logic [REG_ADDR_W-1:0] wr_addr;
  logic                  wr_en;
  logic                  store_done;

  // dest holds the register index for writing classes
  assign wr_addr = commit.dest[REG_ADDR_W-1:0];

  // branches retire without a write, x0 never written
  assign wr_en = commit.commit && (commit.itype != BRANCH) && (wr_addr != '0);

  always_ff @(posedge clk_in) begin
    if (wr_en) begin
      regs[wr_addr] <= commit.value;
    end
  end

  assign reg_data_out = (reg_addr_in == '0) ? '0 : regs[reg_addr_in];

  // store level straight out, address after the cdb base add
  assign store_valid_out = commit.store_valid;
  assign store_addr_out  = commit.dest;
  assign store_data_out  = commit.value;

  // ack only counts while a store is offered
  assign commit.store_ack = store_ack_in && commit.store_valid;
  assign store_done       = commit.store_valid && store_ack_in;

  // one pulse per retired entry, same edge as the regfile write
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      retire_out <= 1'b0;
    end else begin
      retire_out <= commit.commit || store_done;
    end
  end

endmodule

`default_nettype wire

// ==== src/ooo_commit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_commit_top (
  input  wire logic                              clk_in,
  input  wire logic                              rst_in,
  // decoded instruction
  input  wire logic                              instr_valid_in,
  input  wire logic [6:0]                        opcode_in,
  input  wire logic [6:0]                        funct7_in,
  input  wire logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_in,
  input  wire logic [rob_pkg::XLEN-1:0]          imm_in,
  input  wire logic                              pred_taken_in,
  input  wire logic [rob_pkg::XLEN-1:0]          target_in,
  output logic                                   issue_busy_out,
  output rob_pkg::rob_ix_t                       issue_ix_out,
  output logic                                   rob_full_out,
  // common data bus
  input  wire logic                              cdb_valid_in,
  input  wire rob_pkg::rob_ix_t                  cdb_ix_in,
  input  wire logic [rob_pkg::XLEN-1:0]          cdb_value_in,
  input  wire logic [rob_pkg::XLEN-1:0]          cdb_dest_in,
  // operand lookups
  input  wire rob_pkg::rob_ix_t                  lookup1_ix_in,
  input  wire rob_pkg::rob_ix_t                  lookup2_ix_in,
  output logic [rob_pkg::XLEN-1:0]               lookup1_value_out,
  output logic                                   lookup1_ready_out,
  output logic [rob_pkg::XLEN-1:0]               lookup2_value_out,
  output logic                                   lookup2_ready_out,
  // store port
  output logic                                   store_valid_out,
  output logic [rob_pkg::XLEN-1:0]               store_addr_out,
  output logic [rob_pkg::XLEN-1:0]               store_data_out,
  input  wire logic                              store_ack_in,
  // fetch redirect
  output logic                                   redirect_out,
  output logic [rob_pkg::XLEN-1:0]               redirect_pc_out,
  // register file read and retire strobe
  input  wire logic [rv_isa_pkg::REG_ADDR_W-1:0] reg_addr_in,
  output logic [rob_pkg::XLEN-1:0]               reg_data_out,
  output logic                                   retire_out
);

  issue_if  issue_bus ();
  commit_if commit_bus ();

  // full level is shared with the issue unit's hold logic
  assign rob_full_out = issue_bus.rob_full;

  issue_unit issue_unit_i (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .instr_valid_in (instr_valid_in),
    .opcode_in      (opcode_in),
    .funct7_in      (funct7_in),
    .rd_in          (rd_in),
    .imm_in         (imm_in),
    .pred_taken_in  (pred_taken_in),
    .target_in      (target_in),
    .busy_out       (issue_busy_out),
    .issue_ix_out   (issue_ix_out),
    .issue          (issue_bus.producer)
  );

  rob rob_i (
    .clk_in            (clk_in),
    .rst_in            (rst_in),
    .issue             (issue_bus.buffer),
    .commit            (commit_bus.buffer),
    .cdb_valid_in      (cdb_valid_in),
    .cdb_ix_in         (cdb_ix_in),
    .cdb_value_in      (cdb_value_in),
    .cdb_dest_in       (cdb_dest_in),
    .lookup1_ix_in     (lookup1_ix_in),
    .lookup2_ix_in     (lookup2_ix_in),
    .lookup1_value_out (lookup1_value_out),
    .lookup1_ready_out (lookup1_ready_out),
    .lookup2_value_out (lookup2_value_out),
    .lookup2_ready_out (lookup2_ready_out),
    .redirect_out      (redirect_out),
    .redirect_pc_out   (redirect_pc_out)
  );

  commit_unit commit_unit_i (
    .clk_in          (clk_in),
    .rst_in          (rst_in),
    .commit          (commit_bus.retire),
    .store_valid_out (store_valid_out),
    .store_addr_out  (store_addr_out),
    .store_data_out  (store_data_out),
    .store_ack_in    (store_ack_in),
    .reg_addr_in     (reg_addr_in),
    .reg_data_out    (reg_data_out),
    .retire_out      (retire_out)
  );

endmodule

`default_nettype wire

// ==== test/rob_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_assertions (
  input wire logic              clk_in,
  input wire logic              rst_in,
  input wire rob_pkg::rob_ptr_t count,
  input wire logic              commit_level,
  input wire logic              store_level,
  input wire logic              redirect
);
  import rob_pkg::*;

  // tail minus head never passes the entry count
  occupancy_bound: assert property (@(posedge clk_in) disable iff (rst_in)
    count <= rob_ptr_t'(ROB_SIZE))
    else $error("occupancy above %0d entries", ROB_SIZE);

  // head is either a plain commit or a store, never both
  commit_or_store: assert property (@(posedge clk_in) disable iff (rst_in)
    !(commit_level && store_level))
    else $error("commit and store_valid high together");

  // redirect strobe is a single cycle
  redirect_one_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
    redirect |=> !redirect)
    else $error("redirect held longer than one cycle");

  // once full, occupancy can only hold or shrink
  no_alloc_when_full: assert property (@(posedge clk_in) disable iff (rst_in)
    (count == rob_ptr_t'(ROB_SIZE)) |=> (count <= $past(count)))
    else $error("entry allocated while full");

endmodule

bind rob rob_assertions rob_assertions_i (
  .clk_in       (clk_in),
  .rst_in       (rst_in),
  .count        (count),
  .commit_level (commit.commit),
  .store_level  (commit.store_valid),
  .redirect     (redirect_out)
);

`default_nettype wire

// ==== test/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import rv_isa_pkg::*;
  import rob_pkg::*;

  localparam int ISSUE_TIMEOUT  = 50;
  localparam int RETIRE_TIMEOUT = 100;

  // one instruction of the stimulus table
  typedef struct packed {
    logic [6:0]  opcode;
    logic [6:0]  funct7;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic [31:0] cdb_value;
    logic [31:0] cdb_base;
    logic [31:0] expected;
  } row_t;

  logic clk_in, rst_in;
  logic instr_valid_in, pred_taken_in;
  logic [6:0] opcode_in, funct7_in;
  logic [4:0] rd_in, reg_addr_in;
  logic [31:0] imm_in, target_in, cdb_value_in, cdb_dest_in;
  logic issue_busy_out, rob_full_out, cdb_valid_in;
  rob_ix_t issue_ix_out, cdb_ix_in, lookup1_ix_in, lookup2_ix_in;
  logic [31:0] lookup1_value_out, lookup2_value_out, reg_data_out;
  logic lookup1_ready_out, lookup2_ready_out;
  logic store_valid_out, store_ack_in, redirect_out, retire_out;
  logic [31:0] store_addr_out, store_data_out, redirect_pc_out;

  row_t        rows [$];
  rob_ix_t     issued [$];
  logic [31:0] store_addr_q [$];
  logic [31:0] store_data_q [$];
  // register file scoreboard
  // only known entries are compared
  logic [31:0] exp_regs [32];
  logic [31:0] reg_known;
  rob_ix_t     exp_tail;
  int          retired;
  int          seed = 95;

  ooo_commit_top dut_i (.*);

  always #4 clk_in = ~clk_in;

  // retire pulses seen at the edge
  always @(posedge clk_in) begin
    if (rst_in) begin
      retired <= 0;
    end else if (retire_out) begin
      retired <= retired + 1;
    end
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_ix(input string name, input rob_ix_t got, input rob_ix_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "index mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "level mismatch");
    end
  endtask

  task automatic add_row(input logic [6:0] opcode, input logic [6:0] funct7,
                         input logic [4:0] rd, input logic [31:0] imm,
                         input logic [31:0] value, input logic [31:0] base,
                         input logic [31:0] expected);
    row_t r;
    r = '{opcode, funct7, rd, imm, value, base, expected};
    rows.push_back(r);
  endtask

  task automatic record_reg(input logic [4:0] rd, input logic [31:0] value);
    exp_regs[rd]  = value;
    reg_known[rd] = 1'b1;
  endtask

  // one-cycle instruction strobe
  // busy must rise behind it
  task automatic drive_instr(input logic [6:0] opcode, input logic [6:0] funct7,
                             input logic [4:0] rd, input logic [31:0] imm,
                             input logic pred, input logic [31:0] target);
    @(posedge clk_in);
    #1;
    instr_valid_in = 1'b1;
    opcode_in      = opcode;
    funct7_in      = funct7;
    rd_in          = rd;
    imm_in         = imm;
    pred_taken_in  = pred;
    target_in      = target;
    @(posedge clk_in);
    #1;
    instr_valid_in = 1'b0;
    check_bit("issue_busy_out", issue_busy_out, 1'b1);
  endtask

  // busy falls on allocation
  // index must follow the tail
  task automatic wait_issued(output rob_ix_t ix);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_in);
      #1;
      cycles++;
      if (cycles > ISSUE_TIMEOUT) begin
        report_failure("issue unit stayed busy past the timeout");
      end
    end while (issue_busy_out);
    check_ix("issue_ix_out", issue_ix_out, exp_tail);
    ix       = issue_ix_out;
    exp_tail = exp_tail + 1'b1;
  endtask

  task automatic cdb_write(input rob_ix_t ix, input logic [31:0] value,
                           input logic [31:0] base);
    @(posedge clk_in);
    #1;
    cdb_valid_in = 1'b1;
    cdb_ix_in    = ix;
    cdb_value_in = value;
    cdb_dest_in  = base;
    @(posedge clk_in);
    #1;
    cdb_valid_in = 1'b0;
  endtask

  task automatic wait_retires(input int target);
    int cycles;
    cycles = 0;
    while (retired < target) begin
      @(posedge clk_in);
      #1;
      cycles++;
      if (cycles > RETIRE_TIMEOUT) begin
        report_failure("entries did not retire before the timeout");
      end
    end
  endtask

  task automatic check_regs();
    for (int r = 0; r < 32; r++) begin
      if (r == 0 || reg_known[r[4:0]]) begin
        @(posedge clk_in);
        #1;
        reg_addr_in = r[4:0];
        #2;
        check_word($sformatf("reg_data_out x%0d", r), reg_data_out, exp_regs[r[4:0]]);
      end
    end
  endtask

  // memory side of the store port
  // acks after a random delay
  initial begin : store_responder
    int          delay;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    store_ack_in = 1'b0;
    forever begin
      @(posedge clk_in);
      #1;
      if (store_valid_out === 1'b1) begin
        if (store_addr_q.size() == 0) begin
          report_failure("store offered while no store was issued");
        end
        exp_addr = store_addr_q.pop_front();
        exp_data = store_data_q.pop_front();
        check_word("store_addr_out", store_addr_out, exp_addr);
        check_word("store_data_out", store_data_out, exp_data);
        delay = ($random(seed) & 32'h3) + 1;
        // nothing behind the store may retire
        repeat (delay) begin
          @(posedge clk_in);
          #1;
          check_bit("store_valid_out", store_valid_out, 1'b1);
          check_bit("retire_out", retire_out, 1'b0);
        end
        store_ack_in = 1'b1;
        @(posedge clk_in);
        #1;
        store_ack_in = 1'b0;
      end
    end
  end

  initial begin : main
    row_t    row;
    rob_ix_t ix;
    rob_ix_t br_ix;
    rob_ix_t young_ix;
    clk_in         = 1'b0;
    rst_in         = 1'b1;
    instr_valid_in = 1'b0;
    opcode_in      = '0;
    funct7_in      = '0;
    rd_in          = '0;
    imm_in         = '0;
    pred_taken_in  = 1'b0;
    target_in      = '0;
    cdb_valid_in   = 1'b0;
    cdb_ix_in      = '0;
    cdb_value_in   = '0;
    cdb_dest_in    = '0;
    lookup1_ix_in  = '0;
    lookup2_ix_in  = '0;
    reg_addr_in    = '0;
    exp_tail       = '0;
    reg_known      = '0;
    exp_regs[0]    = '0;

    // opcode, funct7, rd, imm, cdb value, cdb base, register value or store address
    add_row(OPC_OP,    7'h00,         5'd1, 32'h0,         32'h1111_0001, 32'h0,    32'h1111_0001);
    add_row(OPC_OPIMM, 7'h00,         5'd2, 32'h10,        32'h2222_0002, 32'h0,    32'h2222_0002);
    add_row(OPC_LUI,   7'h00,         5'd3, 32'h1234_5000, 32'h1234_5000, 32'h0,    32'h1234_5000);
    add_row(OPC_STORE, 7'h00,         5'd0, 32'h40,        32'hcafe_0004, 32'h1000, 32'h0000_1040);
    add_row(OPC_OP,    FUNCT7_MULDIV, 5'd4, 32'h0,         32'h0000_0c35, 32'h0,    32'h0000_0c35);
    add_row(OPC_OP,    7'h00,         5'd0, 32'h0,         32'hdead_beef, 32'h0,    32'h0);
    add_row(OPC_OPIMM, 7'h00,         5'd6, 32'h6,         32'h6666_0006, 32'h0,    32'h6666_0006);
    add_row(OPC_OP,    7'h00,         5'd7, 32'h0,         32'h7777_0007, 32'h0,    32'h7777_0007);

    repeat (2) @(posedge clk_in);
    #1;
    rst_in = 1'b0;
    check_bit("issue_busy_out", issue_busy_out, 1'b0);
    check_bit("rob_full_out", rob_full_out, 1'b0);
    check_bit("store_valid_out", store_valid_out, 1'b0);
    check_bit("redirect_out", redirect_out, 1'b0);
    check_bit("retire_out", retire_out, 1'b0);

    // issue the whole table before any result comes back
    for (int i = 0; i < rows.size(); i++) begin
      row = rows[i];
      drive_instr(row.opcode, row.funct7, row.rd, row.imm, 1'b0, 32'h0);
      wait_issued(ix);
      issued.push_back(ix);
      if (row.opcode == OPC_STORE) begin
        store_addr_q.push_back(row.expected);
        store_data_q.push_back(row.cdb_value);
      end else if (row.rd != 5'd0) begin
        record_reg(row.rd, row.expected);
      end
    end
    lookup1_ix_in = issued[3];
    #2;
    check_bit("lookup1_ready_out", lookup1_ready_out, 1'b0);

    // results in reverse order
    // head written last
    for (int i = rows.size() - 1; i >= 0; i--) begin
      row = rows[i];
      cdb_write(issued[i], row.cdb_value, row.cdb_base);
      lookup1_ix_in = issued[i];
      lookup2_ix_in = issued[0];
      #2;
      check_word("lookup1_value_out", lookup1_value_out, row.cdb_value);
      check_bit("lookup1_ready_out", lookup1_ready_out, 1'b1);
      if (i > 0) begin
        check_bit("lookup2_ready_out", lookup2_ready_out, 1'b0);
        // younger entries wait for the head
        if (retired != 0) begin
          report_failure("an entry retired before the head result was written");
        end
      end
    end
    // second port on a different written slot
    lookup2_ix_in = issued[rows.size() - 1];
    #2;
    check_word("lookup2_value_out", lookup2_value_out, rows[rows.size() - 1].cdb_value);
    check_bit("lookup2_ready_out", lookup2_ready_out, 1'b1);
    wait_retires(8);
    check_regs();

    // fill all eight slots and hold a ninth
    issued.delete();
    for (int k = 0; k < 8; k++) begin
      drive_instr(OPC_OPIMM, 7'h00, 5'(9 + k), 32'(k), 1'b0, 32'h0);
      wait_issued(ix);
      issued.push_back(ix);
      record_reg(5'(9 + k), 32'h0900_0000 + 32'(k));
    end
    check_bit("rob_full_out", rob_full_out, 1'b1);
    drive_instr(OPC_OP, 7'h00, 5'd17, 32'h0, 1'b0, 32'h0);
    repeat (4) begin
      @(posedge clk_in);
      #1;
      check_bit("issue_busy_out", issue_busy_out, 1'b1);
      check_bit("rob_full_out", rob_full_out, 1'b1);
    end
    for (int k = 0; k < 8; k++) begin
      cdb_write(issued[k], 32'h0900_0000 + 32'(k), 32'h0);
    end
    wait_issued(ix);
    record_reg(5'd17, 32'h1700_0017);
    cdb_write(ix, 32'h1700_0017, 32'h0);
    wait_retires(17);
    check_regs();

    // predicted not taken but resolves taken
    drive_instr(OPC_BRANCH, 7'h00, 5'd0, 32'h0, 1'b0, 32'h0000_2000);
    wait_issued(br_ix);
    drive_instr(OPC_OP, 7'h00, 5'd6, 32'h0, 1'b0, 32'h0);
    wait_issued(young_ix);
    drive_instr(OPC_OP, 7'h00, 5'd7, 32'h0, 1'b0, 32'h0);
    wait_issued(ix);
    cdb_write(young_ix, 32'hbad0_0006, 32'h0);
    cdb_write(br_ix, 32'h1, 32'h0);
    check_bit("redirect_out", redirect_out, 1'b1);
    check_word("redirect_pc_out", redirect_pc_out, 32'h0000_2000);
    exp_tail = br_ix + 1'b1;
    @(posedge clk_in);
    #1;
    check_bit("redirect_out", redirect_out, 1'b0);
    wait_retires(18);
    drive_instr(OPC_OP, 7'h00, 5'd8, 32'h0, 1'b0, 32'h0);
    wait_issued(ix);
    record_reg(5'd8, 32'h0808_0808);
    cdb_write(ix, 32'h0808_0808, 32'h0);
    wait_retires(19);
    check_regs();

    // predicted taken and resolves taken
    // target low bits alias x2
    drive_instr(OPC_BRANCH, 7'h00, 5'd0, 32'h0, 1'b1, 32'h0000_0102);
    wait_issued(ix);
    cdb_write(ix, 32'h1, 32'h0);
    check_bit("redirect_out", redirect_out, 1'b0);
    @(posedge clk_in);
    #1;
    check_bit("redirect_out", redirect_out, 1'b0);
    wait_retires(20);
    check_regs();

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
src/rv_isa_pkg.sv
src/rob_pkg.sv
src/rob_ifs.sv
src/issue_unit.sv
src/rob.sv
src/commit_unit.sv
src/ooo_commit_top.sv
test/rob_assertions.sv
test/tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
  --top-module tb_top \
  -f tb.f \
  -o tb_top_sim
./obj_dir/tb_top_sim
